// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -j 0
TOP       := tb_move_generator
FILELIST  := tb.f
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/move_checker.sv
`timescale 1ns/1ns

module move_checker (
    input  logic                clk_in,
    input  logic                rst_in,
    input  movegen_pkg::board_t board,
    input  logic                board_valid,
    input  logic                board_ready,
    input  movegen_pkg::move_t  move,
    input  logic                move_valid,
    output int                  wrong_count,
    output int                  stream_count,
    output int                  boards_checked
);

    movegen_pkg::move_t expected[$];
    movegen_pkg::move_t want;
    logic active;
    logic prev_ready;
    int move_idx;

    // squares reached from sq along one direction, first occupied square included
    function automatic movegen_pkg::bitboard_t step_targets(input int sq, input int dr,
            input int df, input logic slide, input movegen_pkg::bitboard_t occ);
        movegen_pkg::bitboard_t t;
        int r;
        int f;
        logic stop;
        t = '0;
        r = sq / 8 + dr;
        f = sq % 8 + df;
        stop = 1'b0;
        while (!stop && r >= 0 && r < 8 && f >= 0 && f < 8) begin
            t[r*8 + f] = 1'b1;
            stop = !slide || occ[r*8 + f];
            r += dr;
            f += df;
        end
        return t;
    endfunction

    function automatic movegen_pkg::bitboard_t piece_targets(input movegen_pkg::group_e g,
            input int sq, input movegen_pkg::bitboard_t occ);
        movegen_pkg::bitboard_t t;
        int adr;
        int adf;
        logic use_dir;
        t = '0;
        for (int dr = -2; dr <= 2; dr++) begin
            for (int df = -2; df <= 2; df++) begin
                adr = dr < 0 ? -dr : dr;
                adf = df < 0 ? -df : df;
                case (g)
                    movegen_pkg::GROUP_KING: use_dir = adr <= 1 && adf <= 1 && adr + adf > 0;
                    movegen_pkg::GROUP_KNIGHT: use_dir = adr * adf == 2;
                    movegen_pkg::GROUP_DIAG: use_dir = adr == 1 && adf == 1;
                    default: use_dir = adr + adf == 1;
                endcase
                if (use_dir) begin
                    t |= step_targets(sq, dr, df, g == movegen_pkg::GROUP_DIAG
                                      || g == movegen_pkg::GROUP_ORTHO, occ);
                end
            end
        end
        return t;
    endfunction

    // expected stream: group priority, then ascending source, then ascending destination
    function automatic void build_expected(input movegen_pkg::board_t b);
        movegen_pkg::bitboard_t occ;
        movegen_pkg::bitboard_t own;
        movegen_pkg::bitboard_t srcs;
        movegen_pkg::bitboard_t dsts;
        movegen_pkg::move_t m;
        expected.delete();
        occ = b.knight | b.bishop | b.rook | b.queen
            | (movegen_pkg::bitboard_t'(1) << b.white_king)
            | (movegen_pkg::bitboard_t'(1) << b.black_king);
        own = b.black_to_move ? occ & ~b.white_occ : b.white_occ;
        for (int g = 0; g < movegen_pkg::NUM_GROUPS; g++) begin
            case (g)
                0: srcs = movegen_pkg::bitboard_t'(1)
                        << (b.black_to_move ? b.black_king : b.white_king);
                1: srcs = b.knight & own;
                2: srcs = (b.bishop | b.queen) & own;
                default: srcs = (b.rook | b.queen) & own;
            endcase
            for (int s = 0; s < 64; s++) begin
                if (srcs[s]) begin
                    dsts = piece_targets(movegen_pkg::group_e'(g), s, occ) & ~own;
                    for (int d = 0; d < 64; d++) begin
                        if (dsts[d]) begin
                            m.src = movegen_pkg::square_t'(s);
                            m.dst = movegen_pkg::square_t'(d);
                            expected.push_back(m);
                        end
                    end
                end
            end
        end
    endfunction

    initial begin
        wrong_count = 0;
        stream_count = 0;
        boards_checked = 0;
        active = 1'b0;
        prev_ready = 1'b0;
        move_idx = 0;
    end

    always @(posedge clk_in) begin
        if (!rst_in) begin
            if (move_valid) begin
                if (expected.size() == 0) begin
                    $display("extra move %0d -> %0d after the expected list ran out",
                             move.src, move.dst);
                    stream_count++;
                end else begin
                    want = expected.pop_front();
                    if (move != want) begin
                        $display("FAILED at %0t: board %0d move %0d is %0d -> %0d, want %0d -> %0d",
                                 $time, boards_checked, move_idx, move.src, move.dst,
                                 want.src, want.dst);
                        wrong_count++;
                    end
                end
                move_idx++;
            end
            // board_ready rising closes the current board
            if (active && board_ready && !prev_ready) begin
                if (expected.size() != 0) begin
                    $display("board %0d ended with %0d expected moves never produced",
                             boards_checked, expected.size());
                    stream_count++;
                end
                boards_checked++;
                active = 1'b0;
            end
            if (board_valid && board_ready) begin
                build_expected(board);
                active = 1'b1;
                move_idx = 0;
            end
        end
        prev_ready = board_ready;
    end

endmodule

// File: bench/tb_move_generator.sv
`timescale 1ns/1ns

module tb_move_generator;

    // directed boards plus random boards, each given a generous cycle budget
    localparam int NUM_RANDOM = 60;
    localparam int CYCLE_LIMIT = (NUM_RANDOM + 6) * 300;

    logic clk_in;
    logic rst_in;
    movegen_pkg::board_t board;
    logic board_valid;
    logic board_ready;
    movegen_pkg::move_t move;
    logic move_valid;

    int wrong_count;
    int stream_count;
    int boards_checked;
    int cycles;
    logic [31:0] seed;

    move_generator i_dut (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .board       (board),
        .board_valid (board_valid),
        .board_ready (board_ready),
        .move        (move),
        .move_valid  (move_valid)
    );

    move_checker u_checker (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .board          (board),
        .board_valid    (board_valid),
        .board_ready    (board_ready),
        .move           (move),
        .move_valid     (move_valid),
        .wrong_count    (wrong_count),
        .stream_count   (stream_count),
        .boards_checked (boards_checked)
    );

    always #4 clk_in = ~clk_in;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input int n);
        seed = lcg_step(seed);
        return int'(seed[31:16]) % n;
    endfunction

    function automatic movegen_pkg::bitboard_t sq_bit(input int sq);
        return movegen_pkg::bitboard_t'(1) << sq;
    endfunction

    function automatic movegen_pkg::board_t start_board(input logic black);
        movegen_pkg::board_t b;
        b.knight = 64'h4200_0000_0000_0042;
        b.bishop = 64'h2400_0000_0000_0024;
        b.rook = 64'h8100_0000_0000_0081;
        b.queen = 64'h0800_0000_0000_0008;
        b.white_occ = 64'h0000_0000_0000_00ff;
        b.white_king = 6'd4;
        b.black_king = 6'd60;
        b.black_to_move = black;
        return b;
    endfunction

    // rook d4 and bishop f2 blocked by own pieces, enemy rook g4 and knight g3 in reach
    function automatic movegen_pkg::board_t crowded_board();
        movegen_pkg::board_t b;
        b.knight = sq_bit(43) | sq_bit(25) | sq_bit(11) | sq_bit(22);
        b.bishop = sq_bit(13);
        b.rook = sq_bit(27) | sq_bit(30);
        b.queen = sq_bit(44) | sq_bit(56);
        b.white_occ = sq_bit(0) | sq_bit(27) | sq_bit(13) | sq_bit(44) | sq_bit(43)
                    | sq_bit(25);
        b.white_king = 6'd0;
        b.black_king = 6'd63;
        b.black_to_move = 1'b0;
        return b;
    endfunction

    // white fills every square but h8, nothing of white reaches h8
    function automatic movegen_pkg::board_t boxed_board();
        movegen_pkg::board_t b;
        b.knight = ~(sq_bit(0) | sq_bit(63) | sq_bit(53) | sq_bit(46));
        b.bishop = sq_bit(53) | sq_bit(46);
        b.rook = '0;
        b.queen = '0;
        b.white_occ = ~sq_bit(63);
        b.white_king = 6'd0;
        b.black_king = 6'd63;
        b.black_to_move = 1'b0;
        return b;
    endfunction

    function automatic movegen_pkg::board_t random_board();
        movegen_pkg::board_t b;
        movegen_pkg::bitboard_t used;
        int sq;
        int n;
        b = '0;
        b.white_king = movegen_pkg::square_t'(pick(64));
        used = sq_bit(b.white_king);
        do sq = pick(64); while (used[sq]);
        b.black_king = movegen_pkg::square_t'(sq);
        used |= sq_bit(sq);
        b.white_occ = sq_bit(b.white_king);
        n = 4 + pick(20);
        for (int i = 0; i < n; i++) begin
            do sq = pick(64); while (used[sq]);
            used |= sq_bit(sq);
            case (pick(4))
                0: b.knight |= sq_bit(sq);
                1: b.bishop |= sq_bit(sq);
                2: b.rook |= sq_bit(sq);
                default: b.queen |= sq_bit(sq);
            endcase
            if (pick(2) == 0) begin
                b.white_occ |= sq_bit(sq);
            end
        end
        b.black_to_move = logic'(pick(2));
        return b;
    endfunction

    // hand over one board, optionally poke board_valid while busy, wait for the end
    task automatic run_board(input movegen_pkg::board_t b, input logic poke);
        @(negedge clk_in);
        board = b;
        board_valid = 1'b1;
        while (!board_ready) @(negedge clk_in);
        @(negedge clk_in);
        board_valid = 1'b0;
        if (poke) begin
            board = crowded_board();
            board_valid = 1'b1;
            @(negedge clk_in);
            board_valid = 1'b0;
        end
        while (!board_ready) @(negedge clk_in);
    endtask

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the DUT did not finish its boards within %0d cycles", cycles);
            $display("errors: %0d wrong moves, %0d stream errors, %0d boards checked",
                     wrong_count, stream_count, boards_checked);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;
        board = '0;
        board_valid = 1'b0;
        cycles = 0;
        seed = 32'h5e0db8d1;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        run_board(start_board(1'b0), 1'b0);
        run_board(start_board(1'b1), 1'b0);
        run_board(crowded_board(), 1'b0);
        run_board(boxed_board(), 1'b0);
        run_board(start_board(1'b0), 1'b1);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_board(random_board(), 1'b0);
        end
        repeat (4) @(negedge clk_in);

        $display("errors: %0d wrong moves, %0d stream errors, %0d boards checked",
                 wrong_count, stream_count, boards_checked);
        if (wrong_count == 0 && stream_count == 0 && boards_checked == NUM_RANDOM + 5) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rtl/board_decode.sv
`timescale 1ns/1ns

module board_decode (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  movegen_pkg::board_t    board,
    input  logic                   accept,
    output movegen_pkg::group_sets sets,
    output logic                   load
);

    movegen_pkg::board_t board_q;
    movegen_pkg::bitboard_t kings;
    movegen_pkg::bitboard_t own_king;

    always_ff @(posedge clk_in) begin
        if (accept) begin
            board_q <= board;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            load <= 1'b0;
        end else begin
            load <= accept;
        end
    end

    always_comb begin
        kings = (movegen_pkg::bitboard_t'(1) << board_q.white_king)
              | (movegen_pkg::bitboard_t'(1) << board_q.black_king);
        own_king = movegen_pkg::bitboard_t'(1)
                << (board_q.black_to_move ? board_q.black_king : board_q.white_king);

        sets.occ = board_q.knight | board_q.bishop | board_q.rook | board_q.queen | kings;
        // black owns whatever is occupied and not white
        sets.own = board_q.black_to_move ? sets.occ & ~board_q.white_occ : board_q.white_occ;

        sets.king = own_king;
        sets.knight = board_q.knight & sets.own;
        sets.diag = (board_q.bishop | board_q.queen) & sets.own;
        sets.ortho = (board_q.rook | board_q.queen) & sets.own;
    end

    // two kings on one square would hide one of them from occ
    assert property (@(posedge clk_in) disable iff (rst_in)
        load |-> board_q.white_king != board_q.black_king);

endmodule

// File: rtl/leaper_attacks.sv
`timescale 1ns/1ns

module leaper_attacks (
    input  movegen_pkg::square_t   king_sq,
    input  movegen_pkg::square_t   knight_sq,
    output movegen_pkg::bitboard_t king_mask,
    output movegen_pkg::bitboard_t knight_mask
);

    localparam int KING_BITS = movegen_pkg::KING_PAD * movegen_pkg::KING_PAD;
    localparam int KNIGHT_BITS = movegen_pkg::KNIGHT_PAD * movegen_pkg::KNIGHT_PAD;

    // padded index of a1 on each board
    localparam int KING_ORIGIN = movegen_pkg::KING_PAD + 1;
    localparam int KNIGHT_ORIGIN = 2 * movegen_pkg::KNIGHT_PAD + 2;

    logic [KING_BITS-1:0] king_full;
    logic [KNIGHT_BITS-1:0] knight_full;
    logic [7:0] king_shift;
    logic [7:0] knight_shift;

    always_comb begin
        king_shift = 8'(king_sq[5:3]) * 8'(movegen_pkg::KING_PAD) + 8'(king_sq[2:0]);
        knight_shift = 8'(knight_sq[5:3]) * 8'(movegen_pkg::KNIGHT_PAD)
                     + 8'(knight_sq[2:0]);

        king_full = movegen_pkg::KING_PATTERN << king_shift;
        knight_full = movegen_pkg::KNIGHT_PATTERN << knight_shift;
    end

    // keep the eight real files of each real rank, edge wraps land in the padding
    always_comb begin
        for (int r = 0; r < 8; r++) begin
            king_mask[r*8 +: 8] = king_full[r*movegen_pkg::KING_PAD + KING_ORIGIN +: 8];
            knight_mask[r*8 +: 8] =
                knight_full[r*movegen_pkg::KNIGHT_PAD + KNIGHT_ORIGIN +: 8];
        end
    end

endmodule

// File: rtl/move_generator.sv
`timescale 1ns/1ns

module move_generator (
    input  logic                clk_in,
    input  logic                rst_in,
    input  movegen_pkg::board_t board,
    input  logic                board_valid,
    output logic                board_ready,
    output movegen_pkg::move_t  move,
    output logic                move_valid
);

    movegen_pkg::group_sets sets;
    logic load;
    logic accept;

    movegen_pkg::square_t king_sq;
    movegen_pkg::square_t knight_sq;
    movegen_pkg::square_t diag_sq;
    movegen_pkg::square_t ortho_sq;
    movegen_pkg::bitboard_t king_atk;
    movegen_pkg::bitboard_t knight_atk;
    movegen_pkg::bitboard_t diag_atk;
    movegen_pkg::bitboard_t ortho_atk;

    movegen_pkg::scan_offer offers [movegen_pkg::NUM_GROUPS];
    logic [movegen_pkg::NUM_GROUPS-1:0] grants;

    board_decode u_decode (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .board  (board),
        .accept (accept),
        .sets   (sets),
        .load   (load)
    );

    leaper_attacks u_leaper (
        .king_sq     (king_sq),
        .knight_sq   (knight_sq),
        .king_mask   (king_atk),
        .knight_mask (knight_atk)
    );

    // sliders see the registered occupancy of the current board
    slider_attacks u_slider (
        .diag_sq    (diag_sq),
        .ortho_sq   (ortho_sq),
        .occ        (sets.occ),
        .diag_mask  (diag_atk),
        .ortho_mask (ortho_atk)
    );

    piece_scanner u_king (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .load   (load),
        .sources(sets.king),
        .own    (sets.own),
        .attacks(king_atk),
        .grant  (grants[movegen_pkg::GROUP_KING]),
        .src    (king_sq),
        .offer  (offers[movegen_pkg::GROUP_KING])
    );

    piece_scanner u_knight (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .load   (load),
        .sources(sets.knight),
        .own    (sets.own),
        .attacks(knight_atk),
        .grant  (grants[movegen_pkg::GROUP_KNIGHT]),
        .src    (knight_sq),
        .offer  (offers[movegen_pkg::GROUP_KNIGHT])
    );

    piece_scanner u_diag (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .load   (load),
        .sources(sets.diag),
        .own    (sets.own),
        .attacks(diag_atk),
        .grant  (grants[movegen_pkg::GROUP_DIAG]),
        .src    (diag_sq),
        .offer  (offers[movegen_pkg::GROUP_DIAG])
    );

    piece_scanner u_ortho (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .load   (load),
        .sources(sets.ortho),
        .own    (sets.own),
        .attacks(ortho_atk),
        .grant  (grants[movegen_pkg::GROUP_ORTHO]),
        .src    (ortho_sq),
        .offer  (offers[movegen_pkg::GROUP_ORTHO])
    );

    move_sequencer u_sequencer (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .offers      (offers),
        .board_valid (board_valid),
        .grants      (grants),
        .accept      (accept),
        .move        (move),
        .move_valid  (move_valid),
        .board_ready (board_ready)
    );

endmodule

// File: rtl/move_sequencer.sv
`timescale 1ns/1ns

module move_sequencer (
    input  logic                          clk_in,
    input  logic                          rst_in,
    input  movegen_pkg::scan_offer        offers [movegen_pkg::NUM_GROUPS],
    input  logic                          board_valid,
    output logic [movegen_pkg::NUM_GROUPS-1:0] grants,
    output logic                          accept,
    output movegen_pkg::move_t            move,
    output logic                          move_valid,
    output logic                          board_ready
);

    movegen_pkg::group_e sel;
    logic any_valid;
    logic all_done;
    logic pending;

    always_comb begin
        sel = movegen_pkg::GROUP_KING;
        any_valid = 1'b0;
        all_done = 1'b1;
        // a group only gets its turn once every higher group is done
        for (int g = 0; g < movegen_pkg::NUM_GROUPS; g++) begin
            if (offers[g].valid && all_done) begin
                sel = movegen_pkg::group_e'(g);
                any_valid = 1'b1;
            end
            all_done = all_done & offers[g].done;
        end
        grants = '0;
        grants[sel] = any_valid;
    end

    // pending covers the load cycle, when the scanners still show the old board
    assign board_ready = all_done && !pending && !move_valid;
    assign accept = board_valid && board_ready;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            move_valid <= 1'b0;
            pending <= 1'b0;
        end else begin
            move_valid <= any_valid;
            pending <= accept;
        end
    end

    always_ff @(posedge clk_in) begin
        if (any_valid) begin
            move <= offers[sel].move;
        end
    end

    // scanners that report done have nothing left to offer
    assert property (@(posedge clk_in) disable iff (rst_in) board_ready |-> !any_valid);

endmodule

// File: rtl/movegen_pkg.sv
package movegen_pkg;

    // row pitch of the padded boards used by the leaper patterns
    localparam int KING_PAD = 10;
    localparam int KNIGHT_PAD = 12;

    localparam int NUM_GROUPS = 4;

    // square index is {rank, file}
    typedef logic [5:0] square_t;
    typedef logic [63:0] bitboard_t;

    typedef struct packed {
        bitboard_t knight;
        bitboard_t bishop;
        bitboard_t rook;
        bitboard_t queen;
        // every white piece, white king included
        bitboard_t white_occ;
        square_t white_king;
        square_t black_king;
        logic black_to_move;
    } board_t;

    typedef struct packed {
        square_t src;
        square_t dst;
    } move_t;

    // scanner groups, highest priority first
    typedef enum logic [1:0] {
        GROUP_KING,
        GROUP_KNIGHT,
        GROUP_DIAG,
        GROUP_ORTHO
    } group_e;

    typedef struct packed {
        bitboard_t occ;
        bitboard_t own;
        bitboard_t king;
        bitboard_t knight;
        bitboard_t diag;
        bitboard_t ortho;
    } group_sets;

    typedef struct packed {
        logic valid;
        move_t move;
        logic done;
    } scan_offer;

    // king steps around padded square 11, centre left out
    localparam logic [KING_PAD*KING_PAD-1:0] KING_PATTERN = 100'h70_1407;

    // knight jumps around padded square 26
    localparam logic [KNIGHT_PAD*KNIGHT_PAD-1:0] KNIGHT_PATTERN = 144'ha_0110_0001_100a;

    // a1-h8 and h1-a8
    localparam bitboard_t DIAG_BASE = 64'h8040_2010_0804_0201;
    localparam bitboard_t ANTIDIAG_BASE = 64'h0102_0408_1020_4080;

endpackage

// File: rtl/piece_scanner.sv
`timescale 1ns/1ns

module piece_scanner (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   load,
    input  movegen_pkg::bitboard_t sources,
    input  movegen_pkg::bitboard_t own,
    input  movegen_pkg::bitboard_t attacks,
    input  logic                   grant,
    output movegen_pkg::square_t   src,
    output movegen_pkg::scan_offer offer
);

    typedef enum logic {
        ST_FETCH,
        ST_OFFER
    } state_e;

    state_e state;
    movegen_pkg::bitboard_t src_left;
    movegen_pkg::bitboard_t dst_left;
    logic last_dst;

    function automatic movegen_pkg::square_t lowest_square(movegen_pkg::bitboard_t bits);
        movegen_pkg::square_t idx;
        idx = '0;
        for (int i = 63; i >= 0; i--) begin
            if (bits[i]) begin
                idx = movegen_pkg::square_t'(i);
            end
        end
        return idx;
    endfunction

    assign src = lowest_square(src_left);
    assign last_dst = (dst_left & (dst_left - 64'd1)) == '0;

    always_comb begin
        offer.valid = (state == ST_OFFER) && (dst_left != '0);
        offer.move.src = src;
        offer.move.dst = lowest_square(dst_left);
        offer.done = src_left == '0;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= ST_FETCH;
            src_left <= '0;
        end else if (load) begin
            state <= ST_FETCH;
            src_left <= sources;
        end else if (state == ST_FETCH) begin
            if (src_left != '0) begin
                state <= ST_OFFER;
            end
        end else if (dst_left == '0 || (grant && last_dst)) begin
            // source used up, fetch the next one
            state <= ST_FETCH;
            src_left <= src_left & (src_left - 64'd1);
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == ST_FETCH) begin
            dst_left <= attacks & ~own;
        end else if (grant) begin
            dst_left <= dst_left & (dst_left - 64'd1);
        end
    end

    // a grant without a live offer would drop a destination
    assert property (@(posedge clk_in) disable iff (rst_in) grant |-> offer.valid);

endmodule

// File: rtl/slider_attacks.sv
`timescale 1ns/1ns

module slider_attacks (
    input  movegen_pkg::square_t   diag_sq,
    input  movegen_pkg::square_t   ortho_sq,
    input  movegen_pkg::bitboard_t occ,
    output movegen_pkg::bitboard_t diag_mask,
    output movegen_pkg::bitboard_t ortho_mask
);

    movegen_pkg::bitboard_t diag_piece;
    movegen_pkg::bitboard_t ortho_piece;
    movegen_pkg::bitboard_t diag_occ;
    movegen_pkg::bitboard_t ortho_occ;
    movegen_pkg::bitboard_t diag_line;
    movegen_pkg::bitboard_t anti_line;
    movegen_pkg::bitboard_t rank_line;
    movegen_pkg::bitboard_t file_line;
    logic [3:0] anti_sum;
    logic [3:0] anti_dist;

    // vertical flip, reverses the order along files and diagonals
    function automatic movegen_pkg::bitboard_t flip_ranks(movegen_pkg::bitboard_t bits);
        movegen_pkg::bitboard_t out;
        for (int r = 0; r < 8; r++) begin
            out[r*8 +: 8] = bits[(7-r)*8 +: 8];
        end
        return out;
    endfunction

    // horizontal mirror, reverses the order along a rank
    function automatic movegen_pkg::bitboard_t mirror_files(movegen_pkg::bitboard_t bits);
        movegen_pkg::bitboard_t out;
        for (int i = 0; i < 64; i++) begin
            out[i] = bits[(i & ~7) | (7 - (i & 7))];
        end
        return out;
    endfunction

    // o - 2s borrows up to the first blocker, reversed board does the same downwards
    function automatic movegen_pkg::bitboard_t line_attacks(
        movegen_pkg::bitboard_t line_occ,
        movegen_pkg::bitboard_t line,
        movegen_pkg::bitboard_t piece,
        logic mirror
    );
        movegen_pkg::bitboard_t fwd;
        movegen_pkg::bitboard_t bwd;
        fwd = line_occ - (piece << 1);
        if (mirror) begin
            bwd = mirror_files(mirror_files(line_occ) - (mirror_files(piece) << 1));
        end else begin
            bwd = flip_ranks(flip_ranks(line_occ) - (flip_ranks(piece) << 1));
        end
        return (fwd ^ bwd) & line;
    endfunction

    always_comb begin
        diag_piece = movegen_pkg::bitboard_t'(1) << diag_sq;
        ortho_piece = movegen_pkg::bitboard_t'(1) << ortho_sq;
        diag_occ = occ & ~diag_piece;
        ortho_occ = occ & ~ortho_piece;

        if (diag_sq[5:3] >= diag_sq[2:0]) begin
            diag_line = movegen_pkg::DIAG_BASE << {diag_sq[5:3] - diag_sq[2:0], 3'b000};
        end else begin
            diag_line = movegen_pkg::DIAG_BASE >> {diag_sq[2:0] - diag_sq[5:3], 3'b000};
        end

        // rank + file is 7 on the long anti-diagonal
        anti_sum = {1'b0, diag_sq[5:3]} + {1'b0, diag_sq[2:0]};
        anti_dist = (anti_sum >= 4'd7) ? anti_sum - 4'd7 : 4'd7 - anti_sum;
        if (anti_sum >= 4'd7) begin
            anti_line = movegen_pkg::ANTIDIAG_BASE << {anti_dist[2:0], 3'b000};
        end else begin
            anti_line = movegen_pkg::ANTIDIAG_BASE >> {anti_dist[2:0], 3'b000};
        end

        rank_line = movegen_pkg::bitboard_t'(8'hff) << {ortho_sq[5:3], 3'b000};
        file_line = 64'h0101_0101_0101_0101 << ortho_sq[2:0];

        diag_mask = line_attacks(diag_occ & diag_line, diag_line, diag_piece, 1'b0)
                  | line_attacks(diag_occ & anti_line, anti_line, diag_piece, 1'b0);
        ortho_mask = line_attacks(ortho_occ & rank_line, rank_line, ortho_piece, 1'b1)
                   | line_attacks(ortho_occ & file_line, file_line, ortho_piece, 1'b0);
    end

endmodule

// File: tb.f
rtl/movegen_pkg.sv
rtl/board_decode.sv
rtl/leaper_attacks.sv
rtl/slider_attacks.sv
rtl/piece_scanner.sv
rtl/move_sequencer.sv
rtl/move_generator.sv
bench/move_checker.sv
bench/tb_move_generator.sv
